//--- design/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam int    NUM_REGS = 32;
    localparam word_t PC_STEP  = 32'd4;
    localparam word_t RESET_PC = 32'h0000_0000;

    localparam logic [5:0] OP_SPECIAL = 6'h00;  // R-format, operation in funct
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

endpackage

//--- design/pipe_if.sv
`timescale 1ns/1ps

interface id_ex_if;
    mips_pkg::alu_op_e   alu_op;
    mips_pkg::word_t     src1;
    mips_pkg::word_t     src2;        // register operand or extended immediate
    mips_pkg::reg_addr_t wa;
    logic                wreg;
    logic                load;
    logic                store;
    mips_pkg::word_t     store_data;
    mips_pkg::word_t     pc;          // carried along for the write-back trace

    modport producer (
        output alu_op, src1, src2, wa, wreg, load, store, store_data, pc
    );

    modport consumer (
        input alu_op, src1, src2, wa, wreg, load, store, store_data, pc
    );
endinterface

interface ex_mem_if;
    mips_pkg::word_t     result;      // memory address for lw and sw
    mips_pkg::reg_addr_t wa;
    logic                wreg;
    logic                load;
    logic                store;
    mips_pkg::word_t     store_data;
    mips_pkg::word_t     pc;

    modport producer (
        output result, wa, wreg, load, store, store_data, pc
    );

    modport consumer (
        input result, wa, wreg, load, store, store_data, pc
    );
endinterface

//--- design/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic            cpu_clk_50m_i,
    input  logic            rst_n_i,
    input  logic            bus_stall_i,
    input  logic            load_hold_i,
    output mips_pkg::word_t pc_o,
    output mips_pkg::word_t inst_addr_o,
    output logic            inst_ce_o
);

    mips_pkg::word_t pc_q;     // address whose word arrives next cycle
    logic            hold;

    assign hold        = bus_stall_i | load_hold_i;
    assign inst_addr_o = pc_q;  // the ROM refetches the same word while held

    always_ff @(posedge cpu_clk_50m_i) begin
        if (!rst_n_i) begin
            pc_q      <= mips_pkg::RESET_PC;
            inst_ce_o <= 1'b0;
        end else begin
            inst_ce_o <= 1'b1;
            if (!hold && inst_ce_o) begin
                pc_q <= pc_q + mips_pkg::PC_STEP;
            end
        end
    end

    // pc of the word now on the instruction bus, as seen by decode
    always_ff @(posedge cpu_clk_50m_i) begin
        if (!hold) begin
            pc_o <= pc_q;
        end
    end

endmodule

//--- design/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                cpu_clk_50m_i,
    input  logic                rst_n_i,
    input  logic                we_i,
    input  mips_pkg::reg_addr_t wa_i,
    input  mips_pkg::word_t     wd_i,
    input  mips_pkg::reg_addr_t ra1_i,
    input  mips_pkg::reg_addr_t ra2_i,
    output mips_pkg::word_t     rd1_o,
    output mips_pkg::word_t     rd2_o
);

    mips_pkg::word_t regs [mips_pkg::NUM_REGS];
    logic            wr_ok;

    assign wr_ok = we_i && (wa_i != '0);  // $zero is never written

    always_ff @(posedge cpu_clk_50m_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < mips_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wa_i] <= wd_i;
        end
    end

    // a read of the register being written returns the new value
    assign rd1_o = (ra1_i == '0) ? '0 : (wr_ok && wa_i == ra1_i) ? wd_i : regs[ra1_i];
    assign rd2_o = (ra2_i == '0) ? '0 : (wr_ok && wa_i == ra2_i) ? wd_i : regs[ra2_i];

    // the write-back stage drops writes to $zero before they reach the port
    zero_reg_clean: assert property (@(posedge cpu_clk_50m_i) disable iff (!rst_n_i)
        we_i |-> wa_i != '0);

endmodule

//--- design/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
    input  logic                cpu_clk_50m_i,
    input  logic                rst_n_i,
    input  logic                bus_stall_i,
    input  mips_pkg::word_t     inst_i,
    input  mips_pkg::word_t     pc_i,
    input  mips_pkg::reg_addr_t ex_wa_i,
    input  logic                ex_wreg_i,
    input  logic                ex_load_i,
    input  mips_pkg::word_t     ex_result_i,
    input  mips_pkg::reg_addr_t mem_wa_i,
    input  logic                mem_wreg_i,
    input  logic                mem_load_i,
    input  mips_pkg::word_t     mem_result_i,
    output mips_pkg::reg_addr_t ra1_o,
    output mips_pkg::reg_addr_t ra2_o,
    input  mips_pkg::word_t     rd1_i,
    input  mips_pkg::word_t     rd2_i,
    output logic                load_hold_o,
    id_ex_if.producer           id_ex
);

    mips_pkg::instr_u    ins;
    mips_pkg::word_t     inst_q;    // word kept while the stage is held
    logic                held_q;
    mips_pkg::alu_op_e   alu_op;
    mips_pkg::reg_addr_t wa;
    logic                use_rs, use_rt, use_imm, zero_ext;
    logic                wreg, load, store;
    mips_pkg::word_t     imm_ext, fwd1, fwd2;
    logic                dep1, dep2;

    // the ROM has moved on to the next word by the second held cycle
    assign ins = held_q ? inst_q : inst_i;

    always_ff @(posedge cpu_clk_50m_i) begin
        if (!rst_n_i) begin
            held_q <= 1'b0;
        end else begin
            held_q <= bus_stall_i | load_hold_o;
        end
    end

    always_ff @(posedge cpu_clk_50m_i) begin
        if (!held_q) begin
            inst_q <= inst_i;
        end
    end

    always_comb begin
        alu_op   = mips_pkg::ALU_NOP;
        wa       = ins.i.rt;
        use_rs   = 1'b0;
        use_rt   = 1'b0;
        use_imm  = 1'b1;
        zero_ext = 1'b0;
        load     = 1'b0;
        store    = 1'b0;
        case (ins.i.opcode)
            mips_pkg::OP_SPECIAL: begin
                wa      = ins.r.rd;
                use_rs  = 1'b1;
                use_rt  = 1'b1;
                use_imm = 1'b0;
                case (ins.r.funct)
                    mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
                    default:           alu_op = mips_pkg::ALU_NOP;
                endcase
            end
            mips_pkg::OP_ADDIU: begin
                alu_op = mips_pkg::ALU_ADD;
                use_rs = 1'b1;
            end
            mips_pkg::OP_ORI: begin
                alu_op   = mips_pkg::ALU_OR;
                use_rs   = 1'b1;
                zero_ext = 1'b1;
            end
            mips_pkg::OP_LUI: begin
                alu_op   = mips_pkg::ALU_LUI;
                zero_ext = 1'b1;
            end
            mips_pkg::OP_LW: begin
                alu_op = mips_pkg::ALU_ADD;  // base plus offset
                use_rs = 1'b1;
                load   = 1'b1;
            end
            mips_pkg::OP_SW: begin
                alu_op = mips_pkg::ALU_ADD;
                use_rs = 1'b1;
                use_rt = 1'b1;               // rt supplies the store data
                store  = 1'b1;
            end
            default: alu_op = mips_pkg::ALU_NOP;
        endcase
    end

    assign wreg    = (alu_op != mips_pkg::ALU_NOP) && !store;
    assign ra1_o   = ins.i.rs;
    assign ra2_o   = ins.r.rt;
    assign imm_ext = zero_ext ? {16'h0000, ins.i.imm} : {{16{ins.i.imm[15]}}, ins.i.imm};

    // newest value wins: execute, then memory, then the register file
    assign fwd1 = (ra1_o != '0 && ex_wreg_i && ex_wa_i == ra1_o)   ? ex_result_i  :
                  (ra1_o != '0 && mem_wreg_i && mem_wa_i == ra1_o) ? mem_result_i : rd1_i;
    assign fwd2 = (ra2_o != '0 && ex_wreg_i && ex_wa_i == ra2_o)   ? ex_result_i  :
                  (ra2_o != '0 && mem_wreg_i && mem_wa_i == ra2_o) ? mem_result_i : rd2_i;

    // load data only exists in write-back, so wait until it is there
    assign dep1 = use_rs && ra1_o != '0 &&
                  ((ex_load_i && ex_wa_i == ra1_o) || (mem_load_i && mem_wa_i == ra1_o));
    assign dep2 = use_rt && ra2_o != '0 &&
                  ((ex_load_i && ex_wa_i == ra2_o) || (mem_load_i && mem_wa_i == ra2_o));
    assign load_hold_o = dep1 | dep2;

    always_ff @(posedge cpu_clk_50m_i) begin
        if (!rst_n_i) begin
            id_ex.alu_op <= mips_pkg::ALU_NOP;
            id_ex.wreg   <= 1'b0;
            id_ex.load   <= 1'b0;
            id_ex.store  <= 1'b0;
        end else if (!bus_stall_i) begin
            id_ex.alu_op <= load_hold_o ? mips_pkg::ALU_NOP : alu_op;  // bubble on hold
            id_ex.wreg   <= wreg & ~load_hold_o;
            id_ex.load   <= load & ~load_hold_o;
            id_ex.store  <= store & ~load_hold_o;
        end
    end

    always_ff @(posedge cpu_clk_50m_i) begin
        if (!bus_stall_i) begin
            id_ex.src1       <= fwd1;
            id_ex.src2       <= use_imm ? imm_ext : fwd2;
            id_ex.wa         <= wa;
            id_ex.store_data <= fwd2;
            id_ex.pc         <= pc_i;
        end
    end

    // a load moves through execute and memory in at most two cycles
    hold_bounded: assert property (@(posedge cpu_clk_50m_i) disable iff (!rst_n_i)
        !(load_hold_o && $past(load_hold_o) && $past(load_hold_o, 2) &&
          !bus_stall_i && !$past(bus_stall_i) && !$past(bus_stall_i, 2)));

endmodule

//--- design/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    input  logic                cpu_clk_50m_i,
    input  logic                rst_n_i,
    input  logic                bus_stall_i,
    id_ex_if.consumer           id_ex,
    ex_mem_if.producer          ex_mem,
    output mips_pkg::reg_addr_t ex_wa_o,
    output logic                ex_wreg_o,
    output logic                ex_load_o,
    output mips_pkg::word_t     ex_result_o
);

    mips_pkg::word_t result;

    always_comb begin
        case (id_ex.alu_op)
            mips_pkg::ALU_ADD: result = id_ex.src1 + id_ex.src2;
            mips_pkg::ALU_SUB: result = id_ex.src1 - id_ex.src2;
            mips_pkg::ALU_AND: result = id_ex.src1 & id_ex.src2;
            mips_pkg::ALU_OR:  result = id_ex.src1 | id_ex.src2;
            mips_pkg::ALU_XOR: result = id_ex.src1 ^ id_ex.src2;
            mips_pkg::ALU_SLT: result = {31'b0, $signed(id_ex.src1) < $signed(id_ex.src2)};
            mips_pkg::ALU_LUI: result = {id_ex.src2[15:0], 16'h0000};
            default:           result = '0;
        endcase
    end

    assign ex_wa_o     = id_ex.wa;
    assign ex_wreg_o   = id_ex.wreg;
    assign ex_load_o   = id_ex.load;   // decode must wait, result is only an address
    assign ex_result_o = result;

    always_ff @(posedge cpu_clk_50m_i) begin
        if (!rst_n_i) begin
            ex_mem.wreg  <= 1'b0;
            ex_mem.load  <= 1'b0;
            ex_mem.store <= 1'b0;
        end else if (!bus_stall_i) begin
            ex_mem.wreg  <= id_ex.wreg;
            ex_mem.load  <= id_ex.load;
            ex_mem.store <= id_ex.store;
        end
    end

    always_ff @(posedge cpu_clk_50m_i) begin
        if (!bus_stall_i) begin
            ex_mem.result     <= result;
            ex_mem.wa         <= id_ex.wa;
            ex_mem.store_data <= id_ex.store_data;
            ex_mem.pc         <= id_ex.pc;
        end
    end

endmodule

//--- design/memory_writeback.sv
`timescale 1ns/1ps

module memory_writeback (
    input  logic                cpu_clk_50m_i,
    input  logic                rst_n_i,
    input  logic                bus_stall_i,
    ex_mem_if.consumer          ex_mem,
    output logic                data_ce_o,
    output logic                data_we_o,
    output mips_pkg::word_t     data_addr_o,
    output mips_pkg::word_t     data_wdata_o,
    input  mips_pkg::word_t     data_rdata_i,
    output mips_pkg::reg_addr_t mem_wa_o,
    output logic                mem_wreg_o,
    output logic                mem_load_o,
    output mips_pkg::word_t     mem_result_o,
    output logic                rf_we_o,
    output mips_pkg::reg_addr_t rf_wa_o,
    output mips_pkg::word_t     rf_wd_o,
    output mips_pkg::word_t     debug_wb_pc_o,
    output logic                debug_wb_rf_wen_o,
    output mips_pkg::reg_addr_t debug_wb_rf_wnum_o,
    output mips_pkg::word_t     debug_wb_rf_wdata_o
);

    logic                wb_wreg_q, wb_load_q;
    mips_pkg::reg_addr_t wb_wa_q;
    mips_pkg::word_t     wb_result_q, wb_pc_q;
    logic                rdata_held_q;  // write-back was frozen last cycle
    mips_pkg::word_t     rdata_q;
    mips_pkg::word_t     load_data;

    assign data_ce_o    = ex_mem.load | ex_mem.store;
    assign data_we_o    = ex_mem.store & ~bus_stall_i;  // the store lands once, on release
    assign data_addr_o  = ex_mem.result;
    assign data_wdata_o = ex_mem.store_data;

    assign mem_wa_o     = ex_mem.wa;
    assign mem_wreg_o   = ex_mem.wreg;
    assign mem_load_o   = ex_mem.load;
    assign mem_result_o = ex_mem.result;

    always_ff @(posedge cpu_clk_50m_i) begin
        if (!rst_n_i) begin
            wb_wreg_q    <= 1'b0;
            wb_load_q    <= 1'b0;
            rdata_held_q <= 1'b0;
        end else begin
            rdata_held_q <= bus_stall_i;
            if (!bus_stall_i) begin
                wb_wreg_q <= ex_mem.wreg;
                wb_load_q <= ex_mem.load;
            end
        end
    end

    always_ff @(posedge cpu_clk_50m_i) begin
        if (!rdata_held_q) begin
            rdata_q <= data_rdata_i;  // the RAM reads the next address while frozen
        end
        if (!bus_stall_i) begin
            wb_wa_q     <= ex_mem.wa;
            wb_result_q <= ex_mem.result;
            wb_pc_q     <= ex_mem.pc;
        end
    end

    assign load_data = rdata_held_q ? rdata_q : data_rdata_i;

    assign rf_we_o = wb_wreg_q && (wb_wa_q != '0) && !bus_stall_i;
    assign rf_wa_o = wb_wa_q;
    assign rf_wd_o = wb_load_q ? load_data : wb_result_q;

    assign debug_wb_pc_o       = wb_pc_q;
    assign debug_wb_rf_wen_o   = rf_we_o;
    assign debug_wb_rf_wnum_o  = wb_wa_q;
    assign debug_wb_rf_wdata_o = rf_wd_o;

    // only a plain store raises the write strobe, and a store writes no register
    we_needs_ce: assert property (@(posedge cpu_clk_50m_i) disable iff (!rst_n_i)
        data_we_o |-> data_ce_o && !ex_mem.load && !ex_mem.wreg);

endmodule

//--- design/minimips32_top.sv
`timescale 1ns/1ps

module minimips32_top (
    input  logic                cpu_clk_50m_i,
    input  logic                rst_n_i,
    output mips_pkg::word_t     inst_addr_o,
    output logic                inst_ce_o,
    input  mips_pkg::word_t     inst_i,
    output logic                data_ce_o,
    output logic                data_we_o,
    output mips_pkg::word_t     data_addr_o,
    output mips_pkg::word_t     data_wdata_o,
    input  mips_pkg::word_t     data_rdata_i,
    input  logic                bus_stall_i,
    output mips_pkg::word_t     debug_wb_pc_o,
    output logic                debug_wb_rf_wen_o,
    output mips_pkg::reg_addr_t debug_wb_rf_wnum_o,
    output mips_pkg::word_t     debug_wb_rf_wdata_o
);

    mips_pkg::word_t     pc;
    logic                load_hold;
    mips_pkg::reg_addr_t ra1, ra2;
    mips_pkg::word_t     rd1, rd2;
    mips_pkg::reg_addr_t ex_wa, mem_wa, rf_wa;
    logic                ex_wreg, ex_load, mem_wreg, mem_load, rf_we;
    mips_pkg::word_t     ex_result, mem_result, rf_wd;

    id_ex_if  id_ex_bus ();
    ex_mem_if ex_mem_bus ();

    fetch_unit fetch_unit_i (
        .cpu_clk_50m_i, .rst_n_i, .bus_stall_i,
        .load_hold_i (load_hold),
        .pc_o        (pc),
        .inst_addr_o, .inst_ce_o
    );

    register_file register_file_i (
        .cpu_clk_50m_i, .rst_n_i,
        .we_i  (rf_we), .wa_i  (rf_wa), .wd_i  (rf_wd),
        .ra1_i (ra1),   .ra2_i (ra2),
        .rd1_o (rd1),   .rd2_o (rd2)
    );

    decode_unit decode_unit_i (
        .cpu_clk_50m_i, .rst_n_i, .bus_stall_i, .inst_i,
        .pc_i         (pc),
        .ex_wa_i      (ex_wa),  .ex_wreg_i  (ex_wreg),
        .ex_load_i    (ex_load), .ex_result_i (ex_result),
        .mem_wa_i     (mem_wa), .mem_wreg_i (mem_wreg),
        .mem_load_i   (mem_load), .mem_result_i (mem_result),
        .ra1_o (ra1), .ra2_o (ra2), .rd1_i (rd1), .rd2_i (rd2),
        .load_hold_o  (load_hold),
        .id_ex        (id_ex_bus.producer)
    );

    execute_unit execute_unit_i (
        .cpu_clk_50m_i, .rst_n_i, .bus_stall_i,
        .id_ex       (id_ex_bus.consumer),
        .ex_mem      (ex_mem_bus.producer),
        .ex_wa_o     (ex_wa),   .ex_wreg_o   (ex_wreg),
        .ex_load_o   (ex_load), .ex_result_o (ex_result)
    );

    memory_writeback memory_writeback_i (
        .cpu_clk_50m_i, .rst_n_i, .bus_stall_i,
        .ex_mem      (ex_mem_bus.consumer),
        .data_ce_o, .data_we_o, .data_addr_o, .data_wdata_o, .data_rdata_i,
        .mem_wa_o    (mem_wa),   .mem_wreg_o   (mem_wreg),
        .mem_load_o  (mem_load), .mem_result_o (mem_result),
        .rf_we_o     (rf_we), .rf_wa_o (rf_wa), .rf_wd_o (rf_wd),
        .debug_wb_pc_o, .debug_wb_rf_wen_o, .debug_wb_rf_wnum_o, .debug_wb_rf_wdata_o
    );

endmodule

//--- bench/tb_minimips32.sv
`timescale 1ns/1ps

module tb_minimips32;

    localparam int          FILE_DEPTH = 256;
    localparam int          MAX_TRACE  = 64;
    localparam logic [31:0] END_MARK   = 32'hffff_ffff;

    logic                cpu_clk_50m_i = 1'b0;
    logic                rst_n_i       = 1'b0;
    mips_pkg::word_t     inst_i        = '0;
    mips_pkg::word_t     data_rdata_i  = '0;
    logic                bus_stall_i   = 1'b0;
    mips_pkg::word_t     inst_addr_o, data_addr_o, data_wdata_o;
    logic                inst_ce_o, data_ce_o, data_we_o;
    mips_pkg::word_t     debug_wb_pc_o, debug_wb_rf_wdata_o;
    logic                debug_wb_rf_wen_o;
    mips_pkg::reg_addr_t debug_wb_rf_wnum_o;

    mips_pkg::word_t file_words [FILE_DEPTH];
    mips_pkg::word_t rom [FILE_DEPTH];
    mips_pkg::word_t ram [FILE_DEPTH];
    mips_pkg::word_t exp_pc [MAX_TRACE];
    mips_pkg::word_t exp_num [MAX_TRACE];
    mips_pkg::word_t exp_data [MAX_TRACE];
    int              section_end [3];
    int              prog_len, n_exp, errs_before;
    int              trace_idx    = 0;
    int              error_count  = 0;
    int              check_count  = 0;
    int              cycles       = 0;
    int              cycle_limit  = 0;
    int              n_loads      = 0;
    int              n_stores     = 0;
    int              access_count = 0;
    int              store_count  = 0;
    int              seed         = 32'h73cd_a731;
    logic            stall_on     = 1'b0;
    logic            timed_out    = 1'b0;

    minimips32_top minimips32_top_i (.*);

    always #10 cpu_clk_50m_i = ~cpu_clk_50m_i;  // 20 ns period

    // instruction ROM, one cycle of latency
    always @(posedge cpu_clk_50m_i) begin
        if (inst_ce_o && inst_addr_o < 4 * FILE_DEPTH) begin
            inst_i <= rom[inst_addr_o[9:2]];
        end else begin
            inst_i <= '0;
        end
    end

    // data RAM, read-first with one cycle of latency
    always @(posedge cpu_clk_50m_i) begin
        if (data_ce_o) begin
            if (data_we_o) begin
                ram[data_addr_o[9:2]] <= data_wdata_o;
            end
            data_rdata_i <= ram[data_addr_o[9:2]];
        end
    end

    always @(posedge cpu_clk_50m_i) begin
        if (stall_on) begin
            bus_stall_i <= ($random(seed) & 3) == 0;  // high about one cycle in four
        end else begin
            bus_stall_i <= 1'b0;
        end
    end

    task automatic show_mismatch(input string name, input mips_pkg::word_t got,
                                 input mips_pkg::word_t want);
        $display("[FAIL] %s: got %h, expected %h", name, got, want);
        error_count++;
    endtask

    // every write-back strobe is matched in order against the next expected entry
    always @(negedge cpu_clk_50m_i) begin
        if (rst_n_i && debug_wb_rf_wen_o === 1'b1) begin
            if (trace_idx >= n_exp) begin
                $display("unexpected write-back of register %0d at pc %h",
                         debug_wb_rf_wnum_o, debug_wb_pc_o);
                error_count++;
            end else begin
                check_count++;
                if (debug_wb_pc_o !== exp_pc[trace_idx]) begin
                    show_mismatch("debug_wb_pc_o", debug_wb_pc_o, exp_pc[trace_idx]);
                end
                if ({27'b0, debug_wb_rf_wnum_o} !== exp_num[trace_idx]) begin
                    show_mismatch("debug_wb_rf_wnum_o", {27'b0, debug_wb_rf_wnum_o},
                                  exp_num[trace_idx]);
                end
                if (debug_wb_rf_wdata_o !== exp_data[trace_idx]) begin
                    show_mismatch("debug_wb_rf_wdata_o", debug_wb_rf_wdata_o,
                                  exp_data[trace_idx]);
                end
            end
            trace_idx++;
        end
    end

    // a memory access leaves the memory stage once, in a cycle without bus stall
    always @(negedge cpu_clk_50m_i) begin
        if (rst_n_i && data_ce_o === 1'b1 && bus_stall_i === 1'b0) begin
            access_count++;
        end
        if (rst_n_i && data_we_o === 1'b1) begin
            store_count++;
        end
    end

    task automatic load_program();
        int pos;
        $readmemh("bench/program_input.mem", file_words);
        prog_len = 0;
        while (prog_len < FILE_DEPTH && file_words[prog_len] !== END_MARK) begin
            prog_len++;
        end
        pos   = prog_len + 1;
        n_exp = 0;
        for (int s = 0; s < 3; s++) begin
            while (pos + 2 < FILE_DEPTH && n_exp < MAX_TRACE && file_words[pos] !== END_MARK) begin
                exp_pc[n_exp]   = file_words[pos];
                exp_num[n_exp]  = file_words[pos + 1];
                exp_data[n_exp] = file_words[pos + 2];
                n_exp++;
                pos += 3;
            end
            section_end[s] = n_exp;
            pos++;
        end
        if (prog_len == FILE_DEPTH || n_exp == 0) begin
            $display("program file has no end marker or no expected write-backs");
            error_count++;
        end
        for (int a = 0; a < FILE_DEPTH; a++) begin
            rom[a] = (a < prog_len) ? file_words[a] : '0;  // words past the program are nops
            ram[a] = 32'hda7a_0000 | (a * 4);              // fill follows the byte address
            if (a < prog_len && file_words[a][31:26] == 6'h23) n_loads++;   // lw
            if (a < prog_len && file_words[a][31:26] == 6'h2b) n_stores++;  // sw
        end
    endtask

    task automatic run_reset(input logic check);
        if (rst_n_i) begin
            @(posedge cpu_clk_50m_i);
            rst_n_i <= 1'b0;
        end
        for (int i = 1; i <= 5; i++) begin
            @(posedge cpu_clk_50m_i);
            if (i == 5) begin
                rst_n_i <= 1'b1;
            end
            @(negedge cpu_clk_50m_i);
            if (check && inst_ce_o !== 1'b0) show_mismatch("inst_ce_o", inst_ce_o, 0);
            if (check && data_we_o !== 1'b0) show_mismatch("data_we_o", data_we_o, 0);
            if (check && debug_wb_rf_wen_o !== 1'b0) begin
                show_mismatch("debug_wb_rf_wen_o", debug_wb_rf_wen_o, 0);
            end
        end
        @(negedge cpu_clk_50m_i);  // first cycle out of reset
        if (check && inst_ce_o !== 1'b1) show_mismatch("inst_ce_o", inst_ce_o, 1);
        if (check && inst_addr_o !== mips_pkg::RESET_PC) begin
            show_mismatch("inst_addr_o", inst_addr_o, mips_pkg::RESET_PC);
        end
        if (check && data_we_o !== 1'b0) show_mismatch("data_we_o", data_we_o, 0);
        trace_idx    = 0;
        cycles       = 0;
        access_count = 0;
        store_count  = 0;
    endtask

    task automatic wait_for_entries(input int target);
        while (trace_idx < target && !timed_out) begin
            @(posedge cpu_clk_50m_i);
            cycles++;
            if (cycles > cycle_limit) begin
                $display("timeout: %0d of %0d write-backs seen after %0d cycles",
                         trace_idx, target, cycles);
                timed_out = 1'b1;
                error_count++;
            end
        end
    endtask

    task automatic idle_cycles(input int count);
        for (int c = 0; c < count && !timed_out; c++) begin
            @(posedge cpu_clk_50m_i);
            cycles++;
        end
    endtask

    // each lw and sw uses the data port once, and each sw writes once
    task automatic check_data_port();
        if (access_count !== n_loads + n_stores) begin
            show_mismatch("data_ce_o", access_count, n_loads + n_stores);
        end
        if (store_count !== n_stores) begin
            show_mismatch("data_we_o", store_count, n_stores);
        end
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: %s (%0d errors)", num, name,
                 (error_count == errs_before && !timed_out) ? "passed" : "failed",
                 error_count - errs_before);
        errs_before = error_count;
    endtask

    initial begin
        errs_before = 0;
        load_program();
        cycle_limit = 8 * prog_len + 100;
        run_reset(1'b1);
        report_test(1, "reset");
        wait_for_entries(section_end[0]);
        report_test(2, "ALU operations");
        wait_for_entries(section_end[1]);
        report_test(3, "forwarding");
        wait_for_entries(section_end[2]);
        idle_cycles(20);  // nothing may write back after the last instruction
        check_data_port();
        report_test(4, "memory and load-use");
        run_reset(1'b0);
        stall_on <= 1'b1;
        wait_for_entries(n_exp);
        idle_cycles(20);
        stall_on <= 1'b0;
        check_data_port();
        report_test(5, "random bus stalls");
        $display("%0d write-backs checked, %0d errors", check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- bench/program_input.mem
// program words from address 0, then ffffffff
// then expected write-backs as pc, register, data, each of 3 sections closed by ffffffff
3c011234 340200f0 2403fffd 34045a5a  // lui ori addiu ori
00222821 00433023 00823824 00244025  // addu subu and or
00824826 0062502a 0043582a 240c0001  // xor slt slt, then the forwarding chain
018c6021 018c6021 258c0010 01826823
01ac6826 340e0100 adc80004 8dcf0004  // sw then lw of 0x104
01ef8021 add00008 8dd20008 26400007  // addiu to $0 must not write back
000d8821 024f9823 ffffffff
// ALU operations
00000000 01 12340000  00000004 02 000000f0  00000008 03 fffffffd
0000000c 04 00005a5a  00000010 05 123400f0  00000014 06 000000f3
00000018 07 00000050  0000001c 08 12345a5a  00000020 09 00005aaa
00000024 0a 00000001  00000028 0b 00000000  ffffffff
// forwarding chain
0000002c 0c 00000001  00000030 0c 00000002  00000034 0c 00000004
00000038 0c 00000014  0000003c 0d ffffff24  00000040 0d ffffff30  ffffffff
// memory and load-use
00000044 0e 00000100  0000004c 0f 12345a5a  00000050 10 2468b4b4
00000058 12 2468b4b4  00000060 11 ffffff30  00000064 13 12345a5a  ffffffff

//--- verilog.f
design/mips_pkg.sv
design/pipe_if.sv
design/fetch_unit.sv
design/register_file.sv
design/decode_unit.sv
design/execute_unit.sv
design/memory_writeback.sv
design/minimips32_top.sv
bench/tb_minimips32.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_minimips32 -f verilog.f -o sim_minimips32
./obj_dir/sim_minimips32 > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
